// ==== all.f ====
+incdir+.
sv32_pkg.sv
mmu_ctrl_pkg.sv
sv32_tlb.sv
sv32_ptw.sv
sv32_xlat_ctrl.sv
sv32_mmu.sv
tb_sv32_mmu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the MMU testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sv32_mmu -f all.f \
    && ./obj_dir/Vtb_sv32_mmu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// ==== tb_sv32_mmu.sv ====
// --------------------------------------
// random testbench for the Sv32 data MMU
// a memory model serves two page tables on the
// four-phase port and a reference model repeats
// the walk, the permission checks and the TLB
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module tb_sv32_mmu;

    localparam int NUM_REQ        = 300;
    localparam int NUM_BYPASS     = 20;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 64;
    localparam int TLB_N          = `MMU_DTLB_ENTRIES;
    // root table in page 2 and level-0 table in page 3
    localparam logic [`MMU_PPN_W-1:0] ROOT_PPN = 22'd2;
    localparam logic [`MMU_PPN_W-1:0] L0_PPN   = 22'd3;

    logic                       clk_i = 1'b0;
    logic                       rst_ni;
    logic                       req_i;
    logic [`MMU_VLEN-1:0]       vaddr_i;
    logic                       is_store_i;
    mmu_ctrl_pkg::priv_lvl_e    priv_lvl_i;
    logic                       sum_i;
    logic                       en_translation_i;
    logic [`MMU_PPN_W-1:0]      satp_ppn_i;
    logic                       flush_i;
    logic                       ack_o;
    logic [`MMU_PLEN-1:0]       paddr_o;
    logic                       fault_o;
    mmu_ctrl_pkg::fault_cause_e fault_cause_o;
    logic                       mem_req_o;
    logic [`MMU_PLEN-1:0]       mem_addr_o;
    logic                       mem_ack_i = 1'b0;
    logic [`MMU_PTE_W-1:0]      mem_rdata_i = '0;

    integer seed       = 12;
    // seed of the memory response delays
    integer delay_seed = 12;
    int     errors     = 0;
    int     cycles     = 0;
    int     mem_reads  = 0;
    int     mem_wait   = 0;
    logic   txn_open   = 1'b0;
    logic   ack_q      = 1'b0;
    logic   req_q      = 1'b0;
    logic   mem_req_q  = 1'b0;
    logic   mem_ack_q  = 1'b0;

    // memory reads so far in the current request
    int                   walk_step = 0;
    logic [31:0]          root_word;
    logic [`MMU_PLEN-1:0] walk_addr;

    // words 0..511 hold the root table and 512..1023 the level-0 table
    logic [31:0]          mem [1024];
    // TLB mirror of the reference model
    sv32_pkg::tlb_entry_t tlb_m [TLB_N];
    logic [TLB_N-1:0]     tlb_v = '0;
    int                   rr    = 0;

    always #2 clk_i = ~clk_i;

    sv32_mmu dut_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_i            (req_i),
        .vaddr_i          (vaddr_i),
        .is_store_i       (is_store_i),
        .priv_lvl_i       (priv_lvl_i),
        .sum_i            (sum_i),
        .en_translation_i (en_translation_i),
        .satp_ppn_i       (satp_ppn_i),
        .flush_i          (flush_i),
        .ack_o            (ack_o),
        .paddr_o          (paddr_o),
        .fault_o          (fault_o),
        .fault_cause_o    (fault_cause_o),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_ack_i        (mem_ack_i),
        .mem_rdata_i      (mem_rdata_i)
    );

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // two table pages folded into the 1024-word array
    function automatic int word_index(input logic [`MMU_PLEN-1:0] addr);
        return int'({addr[12], addr[10:2]});
    endfunction

    // --------------------------------------
    // page tables
    // --------------------------------------
    task automatic random_leaf(output logic [31:0] w);
        int r;
        w = $random(seed);
        r = $random(seed);
        // mostly valid, accessed, dirty leaves
        if (r[2:0] != 3'd0) w[0] = 1'b1;
        if (r[4:3] != 2'd0) w[6] = 1'b1;
        if (r[6:5] != 2'd0) w[7] = 1'b1;
        if ((r[8:7] != 2'd0) && !w[1] && !w[3]) w[1] = 1'b1;
    endtask

    task automatic build_tables();
        logic [31:0] w;
        int          r;
        for (int i = 0; i < 512; i++) begin
            r = $random(seed);
            case (r[1:0])
                // pointer to the level-0 table
                2'd0, 2'd1: w = {L0_PPN, 10'h001};
                2'd2: begin
                    random_leaf(w);
                    // megapage that is now and then misaligned
                    if (r[3:2] != 2'd0) w[19:10] = '0;
                end
                default: begin
                    w = $random(seed);
                    w[31:10] = L0_PPN;
                end
            endcase
            mem[i] = w;
            random_leaf(w);
            mem[512 + i] = w;
        end
    endtask

    // --------------------------------------
    // reference model
    // --------------------------------------
    task automatic predict(input logic [31:0] va, input logic store,
                           input mmu_ctrl_pkg::priv_lvl_e priv, input logic sum,
                           input logic en, output logic [`MMU_PLEN-1:0] paddr,
                           output logic fault, output int reads);
        sv32_pkg::pte_t pte;
        logic           mega;
        logic           hit;
        logic           bad;
        logic [9:0]     vpn1;
        logic [9:0]     vpn0;
        vpn1  = va[31:22];
        vpn0  = va[21:12];
        paddr = {2'b00, va};
        fault = 1'b0;
        reads = 0;
        hit   = 1'b0;
        mega  = 1'b0;
        bad   = 1'b0;
        pte   = '0;
        if (en) begin
            for (int i = 0; i < TLB_N; i++) begin
                if (tlb_v[i] && (tlb_m[i].vpn1 == vpn1)
                        && (tlb_m[i].mega || (tlb_m[i].vpn0 == vpn0))) begin
                    hit  = 1'b1;
                    mega = tlb_m[i].mega;
                    pte  = tlb_m[i].pte;
                end
            end
            if (!hit) begin
                pte   = mem[word_index({ROOT_PPN, vpn1, 2'b00})];
                reads = 1;
                mega  = 1'b1;
                bad   = !pte.v || (pte.w && !pte.r);
                if (!bad && (pte.r || pte.x)) begin
                    bad = (pte.ppn[9:0] != 10'd0);
                end else if (!bad) begin
                    pte   = mem[word_index({pte.ppn, vpn0, 2'b00})];
                    reads = 2;
                    mega  = 1'b0;
                    bad   = !pte.v || (pte.w && !pte.r) || !(pte.r || pte.x);
                end
                // only good walks fill the mirror in round-robin order
                if (!bad) begin
                    tlb_m[rr] = '{vpn1: vpn1, vpn0: vpn0, mega: mega, pte: pte};
                    tlb_v[rr] = 1'b1;
                    rr        = (rr + 1) % TLB_N;
                end
            end
            fault = bad || !pte.a || (store ? (!pte.w || !pte.d) : !pte.r)
                || ((priv == mmu_ctrl_pkg::PRIV_U) && !pte.u)
                || ((priv == mmu_ctrl_pkg::PRIV_S) && pte.u && !sum);
            paddr = mega ? {pte.ppn[21:10], va[21:0]} : {pte.ppn, va[11:0]};
        end
    endtask

    // --------------------------------------
    // core side driver
    // --------------------------------------
    task automatic access(input logic [31:0] va, input logic store,
                          input mmu_ctrl_pkg::priv_lvl_e priv, input logic sum,
                          input logic en, input int hold);
        logic [`MMU_PLEN-1:0] exp_paddr;
        logic                 exp_fault;
        int                   exp_reads;
        int                   reads_before;
        int                   latency;
        predict(va, store, priv, sum, en, exp_paddr, exp_fault, exp_reads);
        reads_before = mem_reads;
        latency      = 0;
        walk_step    = 0;
        @(negedge clk_i);
        vaddr_i          = va;
        is_store_i       = store;
        priv_lvl_i       = priv;
        sum_i            = sum;
        en_translation_i = en;
        req_i            = 1'b1;
        txn_open         = 1'b1;
        while (!ack_o) begin
            @(negedge clk_i);
            latency++;
        end
        check(64'(fault_o), 64'(exp_fault), "fault");
        if (exp_fault) begin
            check(64'(fault_cause_o), store ? 64'd15 : 64'd13, "fault cause");
        end else begin
            check(64'(paddr_o), 64'(exp_paddr), "paddr");
        end
        check(64'(mem_reads - reads_before), 64'(exp_reads), "page table reads");
        // bypass and hit answer in a fixed time
        if (exp_reads == 0) check(64'(latency), 64'd3, "hit latency");
        // back-pressure from the core
        repeat (hold) @(negedge clk_i);
        check(64'(ack_o), 64'd1, "ack while req held");
        req_i = 1'b0;
        while (ack_o) @(negedge clk_i);
        txn_open = 1'b0;
    endtask

    task automatic flush_tlb();
        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        tlb_v   = '0;
    endtask

    // --------------------------------------
    // memory model, four-phase responder
    // --------------------------------------
    always @(negedge clk_i) begin
        if (mem_req_o && !mem_ack_i) begin
            if (mem_wait > 0) begin
                mem_wait--;
            end else begin
                // level 1 read from satp, level 0 read from the root PTE
                root_word = mem[word_index({satp_ppn_i, vaddr_i[31:22], 2'b00})];
                if (walk_step == 0) begin
                    walk_addr = {satp_ppn_i, vaddr_i[31:22], 2'b00};
                end else begin
                    walk_addr = {root_word[31:10], vaddr_i[21:12], 2'b00};
                end
                check(64'(mem_addr_o), 64'(walk_addr), "page table address");
                walk_step++;
                mem_rdata_i = mem[word_index(mem_addr_o)];
                mem_ack_i   = 1'b1;
                mem_reads++;
                mem_wait    = {$random(delay_seed)} % 4;
            end
        end else if (!mem_req_o && mem_ack_i) begin
            mem_ack_i = 1'b0;
        end
    end

    // handshake rules and run limit
    always @(posedge clk_i) begin
        if (rst_ni) begin
            cycles++;
            check(64'(ack_o && !txn_open), 64'd0, "ack outside a request");
            check(64'(ack_q && req_q && !ack_o), 64'd0, "ack dropped with req high");
            check(64'(mem_req_q && !mem_ack_q && !mem_req_o), 64'd0,
                  "mem_req dropped before mem_ack");
        end
        ack_q     = ack_o;
        req_q     = req_i;
        mem_req_q = mem_req_o;
        mem_ack_q = mem_ack_i;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("the run hung, no end after %0d cycles", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // --------------------------------------
    // stimulus
    // --------------------------------------
    initial begin
        logic [31:0]             va;
        logic [31:0]             prev_va;
        int                      r;
        mmu_ctrl_pkg::priv_lvl_e priv;
        rst_ni           = 1'b0;
        req_i            = 1'b0;
        vaddr_i          = '0;
        is_store_i       = 1'b0;
        priv_lvl_i       = mmu_ctrl_pkg::PRIV_S;
        sum_i            = 1'b0;
        en_translation_i = 1'b0;
        satp_ppn_i       = ROOT_PPN;
        flush_i          = 1'b0;
        prev_va          = '0;
        build_tables();
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;
        check(64'(ack_o), 64'd0, "ack after reset");
        check(64'(mem_req_o), 64'd0, "mem_req after reset");
        for (int n = 0; n < NUM_REQ; n++) begin
            r  = $random(seed);
            va = $random(seed);
            // few pages so that the TLB both hits and replaces
            if (n >= NUM_BYPASS) begin
                va[31:22] = 10'(r[4:3]);
                va[21:12] = 10'(r[7:5]);
                if (r[9:8] == 2'd0) va[31:12] = prev_va[31:12];
                if (r[12:10] == 3'd0) flush_tlb();
            end
            case (r[14:13])
                2'd0:    priv = mmu_ctrl_pkg::PRIV_U;
                2'd1:    priv = mmu_ctrl_pkg::PRIV_S;
                default: priv = mmu_ctrl_pkg::PRIV_M;
            endcase
            access(va, r[15], priv, r[16], (n >= NUM_BYPASS) && (r[19:17] != 3'd0),
                   int'(r[21:20]));
            prev_va = va;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sv32_mmu.sv ====
// --------------------------------------
// data-side Sv32 MMU top level
// controller, TLB and page table walker
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module sv32_mmu (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // core interface
    input  logic                         req_i,
    input  logic [`MMU_VLEN-1:0]         vaddr_i,
    input  logic                         is_store_i,
    input  mmu_ctrl_pkg::priv_lvl_e      priv_lvl_i,
    input  logic                         sum_i,
    input  logic                         en_translation_i,
    input  logic [`MMU_PPN_W-1:0]        satp_ppn_i,
    input  logic                         flush_i,
    output logic                         ack_o,
    output logic [`MMU_PLEN-1:0]         paddr_o,
    output logic                         fault_o,
    output mmu_ctrl_pkg::fault_cause_e   fault_cause_o,
    // page table memory port
    output logic                         mem_req_o,
    output logic [`MMU_PLEN-1:0]         mem_addr_o,
    input  logic                         mem_ack_i,
    input  logic [`MMU_PTE_W-1:0]        mem_rdata_i
);

    logic                      walk_req;
    logic                      walk_done;
    logic                      walk_fault;
    logic                      fill_valid;
    sv32_pkg::tlb_entry_t      fill_entry;
    logic [2*`MMU_VPN_W-1:0]   lookup_vpn;
    logic                      tlb_hit;
    logic                      tlb_mega;
    sv32_pkg::pte_t            tlb_pte;

    // consumer of TLB entries
    sv32_xlat_ctrl xlat_ctrl_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_i            (req_i),
        .vaddr_i          (vaddr_i),
        .is_store_i       (is_store_i),
        .priv_lvl_i       (priv_lvl_i),
        .sum_i            (sum_i),
        .en_translation_i (en_translation_i),
        .ack_o            (ack_o),
        .paddr_o          (paddr_o),
        .fault_o          (fault_o),
        .fault_cause_o    (fault_cause_o),
        .lookup_vpn_o     (lookup_vpn),
        .tlb_hit_i        (tlb_hit),
        .tlb_mega_i       (tlb_mega),
        .tlb_pte_i        (tlb_pte),
        .walk_req_o       (walk_req),
        .walk_done_i      (walk_done),
        .walk_fault_i     (walk_fault)
    );

    // buffer between walker and controller
    sv32_tlb #(
        .ENTRIES (`MMU_DTLB_ENTRIES)
    ) dtlb_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .lookup_vpn_i (lookup_vpn),
        .hit_o        (tlb_hit),
        .mega_o       (tlb_mega),
        .pte_o        (tlb_pte),
        .fill_valid_i (fill_valid),
        .fill_entry_i (fill_entry)
    );

    // producer of TLB entries
    sv32_ptw ptw_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .walk_req_i   (walk_req),
        .vaddr_i      (vaddr_i),
        .satp_ppn_i   (satp_ppn_i),
        .walk_done_o  (walk_done),
        .walk_fault_o (walk_fault),
        .fill_valid_o (fill_valid),
        .fill_entry_o (fill_entry),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i)
    );

endmodule

`default_nettype wire

// ==== sv32_xlat_ctrl.sv ====
// --------------------------------------
// translation controller
// answers the core's four-phase request by bypass,
// TLB hit or walk, and checks page permissions
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module sv32_xlat_ctrl (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // core interface
    input  logic                         req_i,
    input  logic [`MMU_VLEN-1:0]         vaddr_i,
    input  logic                         is_store_i,
    input  mmu_ctrl_pkg::priv_lvl_e      priv_lvl_i,
    input  logic                         sum_i,
    input  logic                         en_translation_i,
    output logic                         ack_o,
    output logic [`MMU_PLEN-1:0]         paddr_o,
    output logic                         fault_o,
    output mmu_ctrl_pkg::fault_cause_e   fault_cause_o,
    // TLB lookup
    output logic [2*`MMU_VPN_W-1:0]      lookup_vpn_o,
    input  logic                         tlb_hit_i,
    input  logic                         tlb_mega_i,
    input  sv32_pkg::pte_t               tlb_pte_i,
    // walker handshake
    output logic                         walk_req_o,
    input  logic                         walk_done_i,
    input  logic                         walk_fault_i
);

    mmu_ctrl_pkg::xlat_state_e state_q;
    logic                      perm_fault;
    logic [`MMU_PLEN-1:0]      paddr_d;

    assign lookup_vpn_o = vaddr_i[`MMU_VLEN-1:`MMU_OFFSET_W];

    // access rights of the hit entry
    always_comb begin
        perm_fault = !tlb_pte_i.a;
        if (is_store_i) begin
            // stores also need the dirty bit, A/D are never updated here
            perm_fault = perm_fault || !tlb_pte_i.w || !tlb_pte_i.d;
        end else begin
            perm_fault = perm_fault || !tlb_pte_i.r;
        end
        if ((priv_lvl_i == mmu_ctrl_pkg::PRIV_U) && !tlb_pte_i.u) begin
            perm_fault = 1'b1;
        end
        // supervisor touches user pages only with SUM
        if ((priv_lvl_i == mmu_ctrl_pkg::PRIV_S) && tlb_pte_i.u && !sum_i) begin
            perm_fault = 1'b1;
        end
    end

    // physical address for bypass, 4 KiB page and megapage
    always_comb begin
        if (!en_translation_i) begin
            paddr_d = {{(`MMU_PLEN-`MMU_VLEN){1'b0}}, vaddr_i};
        end else if (tlb_mega_i) begin
            paddr_d = {tlb_pte_i.ppn[`MMU_PPN_W-1:`MMU_VPN_W], vaddr_i[21:0]};
        end else begin
            paddr_d = {tlb_pte_i.ppn, vaddr_i[`MMU_OFFSET_W-1:0]};
        end
    end

    // --------------------------------------
    // request FSM
    // --------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= mmu_ctrl_pkg::XLAT_IDLE;
            ack_o         <= 1'b0;
            fault_o       <= 1'b0;
            fault_cause_o <= mmu_ctrl_pkg::LOAD_PAGE_FAULT;
            walk_req_o    <= 1'b0;
        end else begin
            case (state_q)
                mmu_ctrl_pkg::XLAT_IDLE: begin
                    if (req_i) state_q <= mmu_ctrl_pkg::XLAT_LOOKUP;
                end
                mmu_ctrl_pkg::XLAT_LOOKUP: begin
                    fault_cause_o <= is_store_i ? mmu_ctrl_pkg::STORE_PAGE_FAULT
                                                : mmu_ctrl_pkg::LOAD_PAGE_FAULT;
                    if (!en_translation_i) begin
                        fault_o <= 1'b0;
                        state_q <= mmu_ctrl_pkg::XLAT_RESPOND;
                    end else if (tlb_hit_i) begin
                        fault_o <= perm_fault;
                        state_q <= mmu_ctrl_pkg::XLAT_RESPOND;
                    end else begin
                        walk_req_o <= 1'b1;
                        state_q    <= mmu_ctrl_pkg::XLAT_WALK;
                    end
                end
                mmu_ctrl_pkg::XLAT_WALK: begin
                    if (walk_done_i) begin
                        walk_req_o <= 1'b0;
                        fault_o    <= walk_fault_i;
                        state_q    <= mmu_ctrl_pkg::XLAT_DROP;
                    end
                end
                mmu_ctrl_pkg::XLAT_DROP: begin
                    // walker handshake closed; a fill is looked up again
                    if (!walk_done_i) begin
                        state_q <= fault_o ? mmu_ctrl_pkg::XLAT_RESPOND
                                           : mmu_ctrl_pkg::XLAT_LOOKUP;
                    end
                end
                mmu_ctrl_pkg::XLAT_RESPOND: begin
                    if (!ack_o) begin
                        ack_o <= 1'b1;
                    end else if (!req_i) begin
                        ack_o   <= 1'b0;
                        state_q <= mmu_ctrl_pkg::XLAT_IDLE;
                    end
                end
                default: state_q <= mmu_ctrl_pkg::XLAT_IDLE;
            endcase
        end
    end

    // result address, meaningful only with ack_o
    always_ff @(posedge clk_i) begin
        if (state_q == mmu_ctrl_pkg::XLAT_LOOKUP) paddr_o <= paddr_d;
    end

endmodule

`default_nettype wire

// ==== sv32_ptw.sv ====
// --------------------------------------
// two-level Sv32 page table walker
// reads PTEs over a four-phase memory port and
// either fills the TLB or reports a walk fault
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module sv32_ptw (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // four-phase walk request from the controller
    input  logic                     walk_req_i,
    input  logic [`MMU_VLEN-1:0]     vaddr_i,
    input  logic [`MMU_PPN_W-1:0]    satp_ppn_i,
    output logic                     walk_done_o,
    output logic                     walk_fault_o,
    // TLB fill
    output logic                     fill_valid_o,
    output sv32_pkg::tlb_entry_t     fill_entry_o,
    // memory port
    output logic                     mem_req_o,
    output logic [`MMU_PLEN-1:0]     mem_addr_o,
    input  logic                     mem_ack_i,
    input  logic [`MMU_PTE_W-1:0]    mem_rdata_i
);

    mmu_ctrl_pkg::ptw_state_e state_q;
    sv32_pkg::pte_t           pte_q;
    logic                     pte_bad;
    logic                     pte_leaf;
    logic                     finish;
    logic                     fault_d;

    // invalid, or the reserved W without R encoding
    assign pte_bad  = !pte_q.v || (pte_q.w && !pte_q.r);
    // R or X marks a leaf, otherwise it points to the next level
    assign pte_leaf = pte_q.r || pte_q.x;

    // end of walk once the memory has dropped its ack
    always_comb begin
        finish  = 1'b0;
        fault_d = 1'b0;
        if ((state_q == mmu_ctrl_pkg::PTW_L1_WAIT) && !mem_ack_i
                && (pte_bad || pte_leaf)) begin
            finish = 1'b1;
            // megapage must be 4 MiB aligned
            fault_d = pte_bad || (pte_q.ppn[`MMU_VPN_W-1:0] != '0);
        end
        if ((state_q == mmu_ctrl_pkg::PTW_L0_WAIT) && !mem_ack_i) begin
            finish  = 1'b1;
            fault_d = pte_bad || !pte_leaf;
        end
    end

    // --------------------------------------
    // control FSM
    // --------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= mmu_ctrl_pkg::PTW_IDLE;
            mem_req_o    <= 1'b0;
            walk_done_o  <= 1'b0;
            walk_fault_o <= 1'b0;
            fill_valid_o <= 1'b0;
        end else begin
            // fill is a single-cycle pulse
            fill_valid_o <= finish && !fault_d;
            if (finish) begin
                walk_done_o  <= 1'b1;
                walk_fault_o <= fault_d;
                state_q      <= mmu_ctrl_pkg::PTW_DONE;
            end
            case (state_q)
                mmu_ctrl_pkg::PTW_IDLE: begin
                    if (walk_req_i) begin
                        mem_req_o <= 1'b1;
                        state_q   <= mmu_ctrl_pkg::PTW_L1_REQ;
                    end
                end
                mmu_ctrl_pkg::PTW_L1_REQ: begin
                    if (mem_ack_i) begin
                        mem_req_o <= 1'b0;
                        state_q   <= mmu_ctrl_pkg::PTW_L1_WAIT;
                    end
                end
                mmu_ctrl_pkg::PTW_L1_WAIT: begin
                    // pointer PTE, go down one level
                    if (!mem_ack_i && !finish) begin
                        mem_req_o <= 1'b1;
                        state_q   <= mmu_ctrl_pkg::PTW_L0_REQ;
                    end
                end
                mmu_ctrl_pkg::PTW_L0_REQ: begin
                    if (mem_ack_i) begin
                        mem_req_o <= 1'b0;
                        state_q   <= mmu_ctrl_pkg::PTW_L0_WAIT;
                    end
                end
                mmu_ctrl_pkg::PTW_DONE: begin
                    // hold done until the controller drops its request
                    if (!walk_req_i) begin
                        walk_done_o  <= 1'b0;
                        walk_fault_o <= 1'b0;
                        state_q      <= mmu_ctrl_pkg::PTW_IDLE;
                    end
                end
                default: ;
            endcase
        end
    end

    // --------------------------------------
    // address, PTE and fill payload
    // --------------------------------------
    always_ff @(posedge clk_i) begin
        case (state_q)
            // level 1: satp.ppn * 4096 + vpn1 * 4
            mmu_ctrl_pkg::PTW_IDLE:
                mem_addr_o <= {satp_ppn_i, vaddr_i[31:22], 2'b00};
            mmu_ctrl_pkg::PTW_L1_REQ,
            mmu_ctrl_pkg::PTW_L0_REQ:
                if (mem_ack_i) pte_q <= sv32_pkg::pte_t'(mem_rdata_i);
            // level 0: pte.ppn * 4096 + vpn0 * 4
            mmu_ctrl_pkg::PTW_L1_WAIT:
                mem_addr_o <= {pte_q.ppn, vaddr_i[21:12], 2'b00};
            default: ;
        endcase
        if (finish) begin
            fill_entry_o <= '{vpn1: vaddr_i[31:22],
                              vpn0: vaddr_i[21:12],
                              mega: (state_q == mmu_ctrl_pkg::PTW_L1_WAIT),
                              pte:  pte_q};
        end
    end

endmodule

`default_nettype wire

// ==== sv32_tlb.sv ====
// --------------------------------------
// fully associative data TLB
// combinational lookup, fill from the walker
// into a round-robin slot, flush of all entries
// --------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "mmu_defs.svh"

module sv32_tlb #(
    parameter int unsigned ENTRIES = `MMU_DTLB_ENTRIES
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    // lookup side, vpn1 in the upper half
    input  logic [2*`MMU_VPN_W-1:0]   lookup_vpn_i,
    output logic                      hit_o,
    output logic                      mega_o,
    output sv32_pkg::pte_t            pte_o,
    // fill side from the walker
    input  logic                      fill_valid_i,
    input  sv32_pkg::tlb_entry_t      fill_entry_i
);

    localparam int unsigned PTR_W = $clog2(ENTRIES);

    sv32_pkg::tlb_entry_t entries_q [ENTRIES];
    logic [ENTRIES-1:0]   valid_q;
    logic [PTR_W-1:0]     rr_ptr_q;
    logic [ENTRIES-1:0]   match;

    // --------------------------------------
    // lookup
    // --------------------------------------
    // a megapage entry ignores vpn0
    always_comb begin
        for (int i = 0; i < ENTRIES; i++) begin
            match[i] = valid_q[i]
                && (entries_q[i].vpn1 == lookup_vpn_i[2*`MMU_VPN_W-1:`MMU_VPN_W])
                && (entries_q[i].mega
                    || (entries_q[i].vpn0 == lookup_vpn_i[`MMU_VPN_W-1:0]));
        end
    end

    // the walker never fills a page twice, so at most one slot matches
    always_comb begin
        hit_o  = 1'b0;
        mega_o = 1'b0;
        pte_o  = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (match[i]) begin
                hit_o  = 1'b1;
                mega_o = entries_q[i].mega;
                pte_o  = entries_q[i].pte;
            end
        end
    end

    // --------------------------------------
    // fill and flush
    // --------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rr_ptr_q <= '0;
        end else begin
            // flush wins, a fill racing it may be stale
            if (flush_i) begin
                valid_q <= '0;
            end else if (fill_valid_i) begin
                valid_q[rr_ptr_q] <= 1'b1;
            end
            // pointer keeps turning across flushes
            if (fill_valid_i) begin
                if (rr_ptr_q == PTR_W'(ENTRIES - 1)) begin
                    rr_ptr_q <= '0;
                end else begin
                    rr_ptr_q <= rr_ptr_q + 1'b1;
                end
            end
        end
    end

    // entry storage, qualified by valid_q
    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            entries_q[rr_ptr_q] <= fill_entry_i;
        end
    end

endmodule

`default_nettype wire

// ==== mmu_ctrl_pkg.sv ====
// --------------------------------------
// control types of the data MMU
// privilege, fault causes and FSM states
// --------------------------------------
`default_nettype none

package mmu_ctrl_pkg;

    // effective privilege of the load or store
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_lvl_e;

    // mcause codes, only page faults are raised here
    typedef enum logic [3:0] {
        LOAD_PAGE_FAULT  = 4'd13,
        STORE_PAGE_FAULT = 4'd15
    } fault_cause_e;

    // page table walker FSM
    typedef enum logic [2:0] {
        PTW_IDLE,
        PTW_L1_REQ,
        PTW_L1_WAIT,
        PTW_L0_REQ,
        PTW_L0_WAIT,
        PTW_DONE
    } ptw_state_e;

    // translation controller FSM
    typedef enum logic [2:0] {
        XLAT_IDLE,
        XLAT_LOOKUP,
        XLAT_WALK,
        XLAT_RESPOND,
        XLAT_DROP
    } xlat_state_e;

endpackage

`default_nettype wire

// ==== sv32_pkg.sv ====
// --------------------------------------
// Sv32 page table format
// PTE layout and the entry kept by the data TLB
// --------------------------------------
`default_nettype none

`include "mmu_defs.svh"

package sv32_pkg;

    // one page table entry, bit 0 is V
    typedef struct packed {
        logic [`MMU_PPN_W-1:0] ppn;
        // reserved for software
        logic [1:0]            rsw;
        logic                  d;
        logic                  a;
        logic                  g;
        logic                  u;
        logic                  x;
        logic                  w;
        logic                  r;
        logic                  v;
    } pte_t;

    // TLB entry, vpn0 is ignored for a megapage
    typedef struct packed {
        logic [`MMU_VPN_W-1:0] vpn1;
        logic [`MMU_VPN_W-1:0] vpn0;
        logic                  mega;
        pte_t                  pte;
    } tlb_entry_t;

endpackage

`default_nettype wire

// ==== mmu_defs.svh ====
// --------------------------------------
// width and sizing macros for the Sv32 data MMU
// include in every file that needs an address,
// PTE or TLB dimension
// --------------------------------------
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// virtual and physical address widths
`define MMU_VLEN 32
`define MMU_PLEN 34

// page numbers and offset
`define MMU_PPN_W 22
`define MMU_VPN_W 10
`define MMU_OFFSET_W 12

// page table entry width
`define MMU_PTE_W 32

// default data TLB depth
`define MMU_DTLB_ENTRIES 4

`endif
